//--- files.f
+incdir+sim
source/fwd_pkg.sv
source/fwd_dest_decode.sv
source/fwd_src_decode.sv
source/fwd_lane.sv
source/forwarding_unit.sv
sim/forwarding_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= forwarding_unit_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?=
PASS_MESSAGE ?= TEST OK

.PHONY: simulate clean

simulate:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) $(VFLAGS)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/fwd_vectors.svh
`ifndef FWD_VECTORS_SVH
`define FWD_VECTORS_SVH

// Each entry is ID/EX, EX/MEM and MEM/WB instructions, then expected lanes A, B and C.
// r_type takes rs, rt, rd and funct. i_type takes opcode, rs and rt.
task automatic fill_vector_table();
	add_vector(NOP, NOP, NOP, FWD_NONE, FWD_NONE, FWD_NONE);
	// Plain R-type bypass from either stage.
	add_vector(r_type(5'd1, 5'd2, 5'd3, FN_ADD), r_type(5'd4, 5'd5, 5'd1, FN_ADD), NOP,
		FWD_EX_MEM, FWD_NONE, FWD_NONE);
	add_vector(r_type(5'd1, 5'd2, 5'd3, FN_ADD), NOP, r_type(5'd4, 5'd5, 5'd1, FN_ADD),
		FWD_MEM_WB, FWD_NONE, FWD_NONE);
	// Both stages write the same register, so EX/MEM wins.
	add_vector(r_type(5'd1, 5'd2, 5'd3, FN_ADD), r_type(5'd4, 5'd5, 5'd2, FN_ADD),
		r_type(5'd6, 5'd7, 5'd2, FN_ADD), FWD_NONE, FWD_EX_MEM, FWD_NONE);
	add_vector(r_type(5'd1, 5'd2, 5'd3, FN_ADD), r_type(5'd4, 5'd5, 5'd1, FN_ADD),
		r_type(5'd6, 5'd7, 5'd1, FN_ADD), FWD_EX_MEM, FWD_NONE, FWD_NONE);
	add_vector(i_type(OP_SW, 5'd4, 5'd5), r_type(5'd1, 5'd2, 5'd5, FN_ADD),
		r_type(5'd1, 5'd2, 5'd5, FN_ADD), FWD_NONE, FWD_NONE, FWD_EX_MEM);
	// Loads only forward from MEM/WB.
	add_vector(r_type(5'd1, 5'd2, 5'd3, FN_ADD), i_type(OP_LW, 5'd7, 5'd1), NOP,
		FWD_NONE, FWD_NONE, FWD_NONE);
	add_vector(r_type(5'd1, 5'd2, 5'd3, FN_ADD), NOP, i_type(OP_LW, 5'd7, 5'd1),
		FWD_MEM_WB, FWD_NONE, FWD_NONE);
	add_vector(r_type(5'd1, 5'd2, 5'd3, FN_ADD), i_type(OP_LBU, 5'd7, 5'd1),
		i_type(OP_LH, 5'd6, 5'd1), FWD_MEM_WB, FWD_NONE, FWD_NONE);
	// Register zero never forwards.
	add_vector(r_type(5'd0, 5'd0, 5'd3, FN_ADD), r_type(5'd1, 5'd2, 5'd0, FN_ADD),
		r_type(5'd1, 5'd2, 5'd0, FN_ADD), FWD_NONE, FWD_NONE, FWD_NONE);
	// A shift by shamt does not read rs.
	add_vector(r_type(5'd1, 5'd2, 5'd4, FN_SLL), r_type(5'd3, 5'd3, 5'd1, FN_ADD),
		r_type(5'd3, 5'd3, 5'd2, FN_ADD), FWD_NONE, FWD_MEM_WB, FWD_NONE);
	add_vector(r_type(5'd1, 5'd2, 5'd0, FN_JR), r_type(5'd3, 5'd3, 5'd2, FN_ADD),
		r_type(5'd3, 5'd3, 5'd1, FN_ADD), FWD_MEM_WB, FWD_NONE, FWD_NONE);
	add_vector(r_type(5'd1, 5'd2, 5'd3, FN_ADD), r_type(5'd3, 5'd0, 5'd1, FN_JR), NOP,
		FWD_NONE, FWD_NONE, FWD_NONE);
	add_vector(r_type(5'd1, 5'd2, 5'd3, FN_ADD), r_type(5'd3, 5'd0, 5'd1, FN_JALR), NOP,
		FWD_EX_MEM, FWD_NONE, FWD_NONE);
	// Store base on lane A and store data on lane C.
	add_vector(i_type(OP_SW, 5'd3, 5'd6), r_type(5'd1, 5'd2, 5'd3, FN_ADD),
		i_type(OP_ADDI, 5'd0, 5'd6), FWD_EX_MEM, FWD_NONE, FWD_MEM_WB);
	add_vector(i_type(OP_SB, 5'd5, 5'd5), r_type(5'd1, 5'd2, 5'd5, FN_ADD), NOP,
		FWD_EX_MEM, FWD_NONE, FWD_EX_MEM);
	// Branches and immediates.
	add_vector(i_type(OP_BEQ, 5'd1, 5'd2), r_type(5'd3, 5'd3, 5'd1, FN_ADD),
		i_type(OP_ADDI, 5'd0, 5'd2), FWD_EX_MEM, FWD_MEM_WB, FWD_NONE);
	add_vector(i_type(OP_BNE, 5'd1, 5'd1), NOP, i_type(OP_ORI, 5'd3, 5'd1),
		FWD_MEM_WB, FWD_MEM_WB, FWD_NONE);
	add_vector(i_type(OP_ORI, 5'd4, 5'd1), r_type(5'd3, 5'd3, 5'd1, FN_ADD),
		r_type(5'd3, 5'd3, 5'd1, FN_ADD), FWD_NONE, FWD_NONE, FWD_NONE);
	add_vector(i_type(OP_LUI, 5'd1, 5'd2), r_type(5'd3, 5'd3, 5'd1, FN_ADD),
		r_type(5'd3, 5'd3, 5'd2, FN_ADD), FWD_NONE, FWD_NONE, FWD_NONE);
	add_vector(i_type(OP_BGTZ, 5'd2, 5'd0), NOP, i_type(OP_LW, 5'd1, 5'd2),
		FWD_MEM_WB, FWD_NONE, FWD_NONE);
endtask

`endif

//--- sim/forwarding_unit_tb.sv
`timescale 1ns/100ps

module forwarding_unit_tb import fwd_pkg::*;
();

	localparam int RESET_CYCLES = 5;
	localparam int RANDOM_COUNT = 500;
	localparam logic [FUNCT_W-1:0] FN_ADD = 6'd32;
	localparam instr_t NOP = '0;

	typedef struct packed {
		instr_t   id_ex;
		instr_t   ex_mem;
		instr_t   mem_wb;
		fwd_sel_t exp_a;
		fwd_sel_t exp_b;
		fwd_sel_t exp_c;
	} vector_t;

	logic     clk;
	logic     rst;
	instr_t   id_ex_instr;
	instr_t   ex_mem_instr;
	instr_t   mem_wb_instr;
	fwd_sel_t forward_a;
	fwd_sel_t forward_b;
	fwd_sel_t forward_c;

	vector_t vectors [$];
	integer  seed;
	int      error_count;
	int      directed_errors;
	int      cycle_count;
	int      cycle_limit;

	opcode_t opcode_list [$] = '{OP_SPECIAL, OP_REGIMM, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
		OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
		OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
	logic [FUNCT_W-1:0] funct_list [$] = '{6'd0, 6'd2, 6'd3, 6'd8, 6'd9,
		6'd32, 6'd34, 6'd37, 6'd42};

	forwarding_unit forwarding_unit_inst
	(
		.id_ex_instr  (id_ex_instr),
		.ex_mem_instr (ex_mem_instr),
		.mem_wb_instr (mem_wb_instr),
		.forward_a    (forward_a),
		.forward_b    (forward_b),
		.forward_c    (forward_c)
	);

	function automatic instr_t r_type(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
		logic [5:0] funct);
		instr_t ins;
		ins = '0;
		ins.rs    = rs;
		ins.rt    = rt;
		ins.rd    = rd;
		ins.funct = funct;
		return ins;
	endfunction

	// The immediate overlaps rd, shamt and funct and is left at zero.
	function automatic instr_t i_type(logic [5:0] opcode, logic [4:0] rs, logic [4:0] rt);
		instr_t ins;
		ins = '0;
		ins.opcode = opcode;
		ins.rs     = rs;
		ins.rt     = rt;
		return ins;
	endfunction

	task automatic add_vector(instr_t id_ex, instr_t ex_mem, instr_t mem_wb,
		fwd_sel_t exp_a, fwd_sel_t exp_b, fwd_sel_t exp_c);
		vector_t v;
		v.id_ex  = id_ex;
		v.ex_mem = ex_mem;
		v.mem_wb = mem_wb;
		v.exp_a  = exp_a;
		v.exp_b  = exp_b;
		v.exp_c  = exp_c;
		vectors.push_back(v);
	endtask

	`include "fwd_vectors.svh"

	// Finds the register that a producer writes.
	function automatic reg_use_t model_dest(instr_t ins);
		reg_use_t d;
		d.en   = 1'b0;
		d.addr = ins.rt;
		case (ins.opcode)
			OP_SPECIAL:
				begin
				d.en   = (ins.funct != FN_JR);
				d.addr = ins.rd;
				end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:
				begin
				d.en = 1'b1;
				end
			default:
				begin
				d.en = 1'b0;
				end
		endcase
		if (d.addr == 5'd0)
			begin
			d.en = 1'b0;
			end
		return d;
	endfunction

	function automatic reg_use_t model_source(instr_t ins, int lane);
		logic     rd_a;
		logic     rd_b;
		logic     rd_c;
		reg_use_t s;
		rd_a = 1'b0;
		rd_b = 1'b0;
		rd_c = 1'b0;
		case (ins.opcode)
			OP_SPECIAL:
				begin
				rd_a = !(ins.funct == FN_SLL || ins.funct == FN_SRL || ins.funct == FN_SRA);
				rd_b = !(ins.funct == FN_JR || ins.funct == FN_JALR);
				end
			OP_BEQ, OP_BNE:
				begin
				rd_a = 1'b1;
				rd_b = 1'b1;
				end
			OP_REGIMM, OP_BLEZ, OP_BGTZ, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
			OP_ORI, OP_XORI, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:
				begin
				rd_a = 1'b1;
				end
			OP_SB, OP_SH, OP_SW:
				begin
				rd_a = 1'b1;
				rd_c = 1'b1;
				end
			default:
				begin
				rd_a = 1'b0;
				end
		endcase
		s.en   = (lane == LANE_A) ? rd_a : ((lane == LANE_B) ? rd_b : rd_c);
		s.addr = (lane == LANE_A) ? ins.rs : ins.rt;
		if (s.addr == 5'd0)
			begin
			s.en = 1'b0;
			end
		return s;
	endfunction

	function automatic fwd_sel_t model_select(instr_t id, instr_t ex, instr_t mem, int lane);
		reg_use_t s;
		reg_use_t e;
		reg_use_t m;
		s = model_source(id, lane);
		e = model_dest(ex);
		m = model_dest(mem);
		// A load in EX/MEM has no data yet.
		if (ex.opcode inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU})
			begin
			e.en = 1'b0;
			end
		if (s.en && e.en && s.addr == e.addr)
			begin
			return FWD_EX_MEM;
			end
		else if (s.en && m.en && s.addr == m.addr)
			begin
			return FWD_MEM_WB;
			end
		else
			begin
			return FWD_NONE;
			end
	endfunction

	task automatic check_lane(string where, string lane, fwd_sel_t expected, fwd_sel_t actual);
		if (actual !== expected)
			begin
			error_count++;
			$display("Error at %0t: %s lane %s expected %0d got %0d",
				$time, where, lane, expected, actual);
			end
	endtask

	task automatic draw_instr(output instr_t ins);
		int pick;
		int r;
		ins = '0;
		pick = $unsigned($random(seed)) % opcode_list.size();
		ins.opcode = opcode_list[pick];
		// Registers come from 0 to 3 so that matches are frequent.
		r = $unsigned($random(seed)) % 4;
		ins.rs = r[4:0];
		r = $unsigned($random(seed)) % 4;
		ins.rt = r[4:0];
		r = $unsigned($random(seed)) % 4;
		ins.rd = r[4:0];
		pick = $unsigned($random(seed)) % funct_list.size();
		ins.funct = funct_list[pick];
	endtask

	initial
		begin
		clk = 1'b0;
		forever #4 clk = ~clk;
		end

	initial
		begin
		@(negedge rst);
		cycle_count = 0;
		while (cycle_count < cycle_limit)
			begin
			@(posedge clk);
			cycle_count++;
			end
		$display("Run timed out after %0d cycles before all tests were applied", cycle_count);
		$display("TEST FAILED");
		$finish;
		end

	initial
		begin
		instr_t id;
		instr_t ex;
		instr_t mem;
		seed         = 32'h922b;
		error_count  = 0;
		rst          = 1'b1;
		id_ex_instr  = '0;
		ex_mem_instr = '0;
		mem_wb_instr = '0;
		fill_vector_table();
		cycle_limit = vectors.size() + RANDOM_COUNT + 20;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		foreach (vectors[i])
			begin
			@(negedge clk);
			id_ex_instr  = vectors[i].id_ex;
			ex_mem_instr = vectors[i].ex_mem;
			mem_wb_instr = vectors[i].mem_wb;
			@(posedge clk);
			check_lane($sformatf("vector %0d", i), "A", vectors[i].exp_a, forward_a);
			check_lane($sformatf("vector %0d", i), "B", vectors[i].exp_b, forward_b);
			check_lane($sformatf("vector %0d", i), "C", vectors[i].exp_c, forward_c);
			end
		directed_errors = error_count;

		for (int n = 0; n < RANDOM_COUNT; n++)
			begin
			@(negedge clk);
			draw_instr(id);
			draw_instr(ex);
			draw_instr(mem);
			id_ex_instr  = id;
			ex_mem_instr = ex;
			mem_wb_instr = mem;
			@(posedge clk);
			check_lane($sformatf("random %0d", n), "A",
				model_select(id, ex, mem, LANE_A), forward_a);
			check_lane($sformatf("random %0d", n), "B",
				model_select(id, ex, mem, LANE_B), forward_b);
			check_lane($sformatf("random %0d", n), "C",
				model_select(id, ex, mem, LANE_C), forward_c);
			end

		$display("Errors: directed %0d, random %0d, total %0d",
			directed_errors, error_count - directed_errors, error_count);
		if (error_count == 0)
			begin
			$display("TEST OK");
			end
		else
			begin
			$display("TEST FAILED");
			end
		$finish;
		end

endmodule

//--- source/forwarding_unit.sv
`timescale 1ns/100ps

module forwarding_unit import fwd_pkg::*;
(
	input  instr_t   id_ex_instr,
	input  instr_t   ex_mem_instr,
	input  instr_t   mem_wb_instr,
	output fwd_sel_t forward_a,
	output fwd_sel_t forward_b,
	output fwd_sel_t forward_c
);

	reg_use_t ex_mem_dest;
	reg_use_t mem_wb_dest;
	reg_use_t ex_mem_fwd;
	reg_use_t lane_src [NUM_LANES];
	fwd_sel_t lane_sel [NUM_LANES];
	logic     ex_is_load;

	fwd_dest_decode ex_mem_dest_inst
	(
		.instr (ex_mem_instr),
		.dest  (ex_mem_dest)
	);

	fwd_dest_decode mem_wb_dest_inst
	(
		.instr (mem_wb_instr),
		.dest  (mem_wb_dest)
	);

	fwd_src_decode src_decode_inst
	(
		.instr (id_ex_instr),
		.src   (lane_src)
	);

	// Load data only exists after the memory access, so an EX/MEM load
	// is hidden here and the match falls through to MEM/WB a cycle later.
	assign ex_is_load = is_load(ex_mem_instr.opcode);

	always_comb
		begin
		ex_mem_fwd = ex_mem_dest;
		if (ex_is_load)
			begin
			ex_mem_fwd.en = 1'b0;
			end
		end

	for (genvar i = 0; i < NUM_LANES; i++)
		begin : g_lane
		fwd_lane lane_inst
		(
			.src         (lane_src[i]),
			.ex_mem_dest (ex_mem_fwd),
			.mem_wb_dest (mem_wb_dest),
			.sel         (lane_sel[i])
		);
		end

	assign forward_a = lane_sel[LANE_A];
	assign forward_b = lane_sel[LANE_B];
	assign forward_c = lane_sel[LANE_C];

endmodule

//--- source/fwd_lane.sv
`timescale 1ns/100ps

module fwd_lane import fwd_pkg::*;
(
	input  reg_use_t src,
	input  reg_use_t ex_mem_dest,
	input  reg_use_t mem_wb_dest,
	output fwd_sel_t sel
);

	logic hit_ex_mem;
	logic hit_mem_wb;

	assign hit_ex_mem = src.en && ex_mem_dest.en && (src.addr == ex_mem_dest.addr);
	assign hit_mem_wb = src.en && mem_wb_dest.en && (src.addr == mem_wb_dest.addr);

	// The younger producer in EX/MEM holds the newer value and wins.
	always_comb
		begin
		if (hit_ex_mem)
			begin
			sel = FWD_EX_MEM;
			end
		else if (hit_mem_wb)
			begin
			sel = FWD_MEM_WB;
			end
		else
			begin
			sel = FWD_NONE;
			end
		end

endmodule

//--- source/fwd_src_decode.sv
`timescale 1ns/100ps

module fwd_src_decode import fwd_pkg::*;
(
	input  instr_t   instr,
	output reg_use_t src [NUM_LANES]
);

	logic [NUM_LANES-1:0] reads;
	logic                 base_user;

	// Loads, stores, branches and most I-type ALU operations read rs.
	assign base_user = is_branch(instr.opcode)
		|| is_alu_imm(instr.opcode)
		|| is_load(instr.opcode)
		|| is_store(instr.opcode);

	always_comb
		begin
		reads = '0;
		case (instr.opcode)
			OP_SPECIAL:
				begin
				reads[LANE_A] = !is_shift_imm(instr.funct);
				// Register jumps have no second ALU operand.
				reads[LANE_B] = !is_jump_reg(instr.funct);
				end
			OP_BEQ, OP_BNE:
				begin
				reads[LANE_A] = 1'b1;
				reads[LANE_B] = 1'b1;
				end
			OP_LUI:
				begin
				// The upper immediate is the whole operand.
				reads = '0;
				end
			default:
				begin
				reads[LANE_A] = base_user;
				// Store data travels on its own lane, apart from the ALU inputs.
				reads[LANE_C] = is_store(instr.opcode);
				end
		endcase
		end

	assign src[LANE_A] = make_use(reads[LANE_A], instr.rs);
	assign src[LANE_B] = make_use(reads[LANE_B], instr.rt);
	assign src[LANE_C] = make_use(reads[LANE_C], instr.rt);

endmodule

//--- source/fwd_dest_decode.sv
`timescale 1ns/100ps

module fwd_dest_decode import fwd_pkg::*;
(
	input  instr_t   instr,
	output reg_use_t dest
);

	logic                  writes;
	logic [REG_ADDR_W-1:0] target;

	always_comb
		begin
		writes = 1'b0;
		target = instr.rt;
		case (instr.opcode)
			OP_SPECIAL:
				begin
				// Every register-register operation except jr writes rd.
				writes = (instr.funct != FN_JR);
				target = instr.rd;
				end
			default:
				begin
				// I-type ALU results and load data land in rt.
				if (is_alu_imm(instr.opcode) || is_load(instr.opcode))
					begin
					writes = 1'b1;
					end
				end
		endcase
		end

	assign dest = make_use(writes, target);

endmodule

//--- source/fwd_pkg.sv
package fwd_pkg;

	localparam int INSTR_W    = 32;
	localparam int OPCODE_W   = 6;
	localparam int REG_ADDR_W = 5;
	localparam int SHAMT_W    = 5;
	localparam int FUNCT_W    = 6;

	// Lanes A and B feed the ALU and lane C carries store data.
	localparam int NUM_LANES = 3;
	localparam int LANE_A    = 0;
	localparam int LANE_B    = 1;
	localparam int LANE_C    = 2;

	typedef enum logic [OPCODE_W-1:0] {
		OP_SPECIAL = 6'd0,
		OP_REGIMM  = 6'd1,
		OP_BEQ     = 6'd4,
		OP_BNE     = 6'd5,
		OP_BLEZ    = 6'd6,
		OP_BGTZ    = 6'd7,
		OP_ADDI    = 6'd8,
		OP_ADDIU   = 6'd9,
		OP_SLTI    = 6'd10,
		OP_SLTIU   = 6'd11,
		OP_ANDI    = 6'd12,
		OP_ORI     = 6'd13,
		OP_XORI    = 6'd14,
		OP_LUI     = 6'd15,
		OP_LB      = 6'd32,
		OP_LH      = 6'd33,
		OP_LW      = 6'd35,
		OP_LBU     = 6'd36,
		OP_LHU     = 6'd37,
		OP_SB      = 6'd40,
		OP_SH      = 6'd41,
		OP_SW      = 6'd43
	} opcode_t;

	// Only the funct codes that change operand use are named.
	typedef enum logic [FUNCT_W-1:0] {
		FN_SLL  = 6'd0,
		FN_SRL  = 6'd2,
		FN_SRA  = 6'd3,
		FN_JR   = 6'd8,
		FN_JALR = 6'd9
	} funct_t;

	typedef enum logic [1:0] {
		FWD_NONE   = 2'd0,
		FWD_MEM_WB = 2'd1,
		FWD_EX_MEM = 2'd2
	} fwd_sel_t;

	typedef struct packed {
		logic [OPCODE_W-1:0]   opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [SHAMT_W-1:0]    shamt;
		logic [FUNCT_W-1:0]    funct;
	} instr_t;

	typedef struct packed {
		logic                  en;
		logic [REG_ADDR_W-1:0] addr;
	} reg_use_t;

	function automatic logic is_load(logic [OPCODE_W-1:0] opcode);
		case (opcode)
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic is_store(logic [OPCODE_W-1:0] opcode);
		case (opcode)
			OP_SB, OP_SH, OP_SW:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic is_alu_imm(logic [OPCODE_W-1:0] opcode);
		case (opcode)
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic is_branch(logic [OPCODE_W-1:0] opcode);
		case (opcode)
			OP_REGIMM, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// Shifts by shamt take their only register operand from rt.
	function automatic logic is_shift_imm(logic [FUNCT_W-1:0] funct);
		case (funct)
			FN_SLL, FN_SRL, FN_SRA:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic is_jump_reg(logic [FUNCT_W-1:0] funct);
		case (funct)
			FN_JR, FN_JALR:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// Register zero is hardwired, so a use of it never takes part in a bypass.
	function automatic reg_use_t make_use(logic en, logic [REG_ADDR_W-1:0] addr);
		reg_use_t use_q;
		use_q.en   = en && (addr != '0);
		use_q.addr = addr;
		return use_q;
	endfunction

endpackage
